// File: include/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

//////////////////////////////
// Counter and threshold widths
//////////////////////////////

// Wide enough for the largest total (SXGA, 1688 pixels)
`define CNT_W            11

//////////////////////////////
// Pixel data
//////////////////////////////

`define COLOR_W          8        // Bits per channel
`define BAR_COUNT        8        // Vertical bars across the active area

//////////////////////////////
// Switch input
//////////////////////////////

// Stable cycles before a new switch code is taken,
// roughly 1.3 ms at 50 MHz
`define DEBOUNCE_LEN_DEF 65536

`endif

// File: design/video_mode_pkg.sv
`include "video_macros.svh"

package video_mode_pkg;

	// Switch codes, same encoding as the board switches
	typedef enum logic [3:0] {
		MODE_VGA    = 4'b0000,
		MODE_SVGA   = 4'b0001,
		MODE_720P   = 4'b0010,
		MODE_XGA    = 4'b0011,
		MODE_SXGA   = 4'b1000,
		MODE_CAMERA = 4'b1001
	} mode_code_e;

	typedef struct packed {
		logic [`CNT_W-1:0] h_active;     // First blank pixel
		logic [`CNT_W-1:0] h_sync_start;
		logic [`CNT_W-1:0] h_sync_end;   // First pixel after sync
		logic [`CNT_W-1:0] h_total;
		logic [`CNT_W-1:0] v_active;
		logic [`CNT_W-1:0] v_sync_start;
		logic [`CNT_W-1:0] v_sync_end;
		logic [`CNT_W-1:0] v_total;
		logic [`CNT_W-1:0] bar_width;    // Pixels per colour bar
		logic              sync_neg;     // Active-low sync
	} mode_timing_t;

	// Builds thresholds from pixels, front porch, sync width and back porch
	function automatic mode_timing_t make_timing(
		input int h_act, input int h_fp, input int h_sw, input int h_bp,
		input int v_act, input int v_fp, input int v_sw, input int v_bp,
		input logic neg
	);
		mode_timing_t t;
		t.h_active     = `CNT_W'(h_act);
		t.h_sync_start = `CNT_W'(h_act + h_fp);
		t.h_sync_end   = `CNT_W'(h_act + h_fp + h_sw);
		t.h_total      = `CNT_W'(h_act + h_fp + h_sw + h_bp);
		t.v_active     = `CNT_W'(v_act);
		t.v_sync_start = `CNT_W'(v_act + v_fp);
		t.v_sync_end   = `CNT_W'(v_act + v_fp + v_sw);
		t.v_total      = `CNT_W'(v_act + v_fp + v_sw + v_bp);
		t.bar_width    = `CNT_W'(h_act / `BAR_COUNT);
		t.sync_neg     = neg;
		return t;
	endfunction

	function automatic mode_timing_t mode_lookup(input logic [3:0] code);
		mode_timing_t t;
		case (code)
			MODE_VGA:    t = make_timing(640, 16, 96, 48, 480, 11, 2, 31, 1'b1);
			MODE_SVGA:   t = make_timing(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);
			MODE_XGA:    t = make_timing(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);
			MODE_SXGA:   t = make_timing(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0);
			MODE_CAMERA: t = make_timing(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);
			default:     t = make_timing(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0); // 720p
		endcase
		return t;
	endfunction

endpackage

// File: design/video_signal_pkg.sv
`include "video_macros.svh"

package video_signal_pkg;

	// Counter outputs, all flags active high
	typedef struct packed {
		logic [`CNT_W-1:0] hcount;
		logic [`CNT_W-1:0] vcount;
		logic              hblank;
		logic              vblank;
		logic              hsync;
		logic              vsync;
	} raster_t;

	// Final video, sync already at the mode's polarity
	typedef struct packed {
		logic               hsync;
		logic               vsync;
		logic               de;
		logic [`COLOR_W-1:0] red;
		logic [`COLOR_W-1:0] green;
		logic [`COLOR_W-1:0] blue;
	} video_out_t;

endpackage

// File: design/mode_select.sv
`include "video_macros.svh"

module mode_select
	import video_mode_pkg::*;
#(
	parameter int DEBOUNCE_LEN = `DEBOUNCE_LEN_DEF
) (
	input  logic         clk50m_bufg,
	input  logic         rstbtn_n,
	input  logic [3:0]   sw,
	output mode_timing_t timing,
	output logic         mode_change
);

	localparam int DB_W = $clog2(DEBOUNCE_LEN + 1);

	logic [3:0]      sw_meta;   // First sync stage
	logic [3:0]      sw_sync;
	logic [3:0]      sw_q;      // Value under debounce
	logic [3:0]      cur_code;  // Raw code in use
	logic [DB_W-1:0] db_cnt;
	logic            sw_stable;
	logic            load;

	assign sw_stable = (sw_sync == sw_q);
	assign load      = sw_stable && (sw_q != cur_code) &&
	                   (db_cnt == DB_W'(DEBOUNCE_LEN - 1));

	//////////////////////////////
	// Synchronizer
	//////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			sw_meta <= MODE_720P;
			sw_sync <= MODE_720P;
			sw_q    <= MODE_720P;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_q    <= sw_sync;
		end
	end

	// Any movement on the input restarts the count
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			db_cnt <= '0;
		end else if (!sw_stable || (sw_q == cur_code) || load) begin
			db_cnt <= '0;
		end else begin
			db_cnt <= db_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Current mode
	//////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			cur_code    <= MODE_720P;
			timing      <= mode_lookup(MODE_720P);
			mode_change <= 1'b0;
		end else begin
			mode_change <= load;         // One cycle wide
			if (load) begin
				cur_code <= sw_q;
				timing   <= mode_lookup(sw_q);
			end
		end
	end

endmodule

// File: design/raster_counter.sv
`include "video_macros.svh"

module raster_counter
	import video_mode_pkg::*;
	import video_signal_pkg::*;
(
	input  logic         clk50m_bufg,
	input  logic         rstbtn_n,
	input  mode_timing_t timing,
	input  logic         mode_change,
	output raster_t      raster
);

	logic [`CNT_W-1:0] h_next;
	logic [`CNT_W-1:0] v_next;
	logic              h_wrap;
	logic              v_wrap;

	assign h_wrap = (raster.hcount == timing.h_total - 1'b1);  // Last pixel of line
	assign v_wrap = (raster.vcount == timing.v_total - 1'b1);  // Last line of frame

	always_comb begin
		h_next = raster.hcount + 1'b1;
		v_next = raster.vcount;
		if (mode_change) begin
			h_next = '0;
			v_next = '0;
		end else if (h_wrap) begin
			h_next = '0;
			v_next = v_wrap ? '0 : raster.vcount + 1'b1;
		end
	end

	//////////////////////////////
	// Counts and decoded flags
	//////////////////////////////
	// Flags come from the next counts so they match what is registered
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			raster <= '0;
		end else begin
			raster.hcount <= h_next;
			raster.vcount <= v_next;
			raster.hblank <= (h_next >= timing.h_active);
			raster.vblank <= (v_next >= timing.v_active);
			raster.hsync  <= (h_next >= timing.h_sync_start) &&
			                 (h_next <  timing.h_sync_end);
			raster.vsync  <= (v_next >= timing.v_sync_start) &&
			                 (v_next <  timing.v_sync_end);
		end
	end

endmodule

// File: design/video_output_stage.sv
`include "video_macros.svh"

module video_output_stage
	import video_mode_pkg::*;
	import video_signal_pkg::*;
(
	input  logic         clk50m_bufg,
	input  logic         rstbtn_n,
	input  mode_timing_t timing,
	input  logic         mode_change,
	input  raster_t      raster,
	output video_out_t   video
);

	localparam int BAR_IDX_W = $clog2(`BAR_COUNT);

	logic                 de_in;
	logic                 hsync_d1;
	logic                 vsync_d1;
	logic                 de_d1;
	logic [`CNT_W-1:0]    pix_cnt;   // Position inside current bar
	logic [BAR_IDX_W-1:0] bar_idx;
	logic [2:0]           rgb;

	// Bar colours as {r, g, b}
	function automatic logic [2:0] bar_rgb(input logic [BAR_IDX_W-1:0] idx);
		case (idx)
			3'd0:    return 3'b111;  // White
			3'd1:    return 3'b110;  // Yellow
			3'd2:    return 3'b011;  // Cyan
			3'd3:    return 3'b010;  // Green
			3'd4:    return 3'b101;  // Magenta
			3'd5:    return 3'b100;  // Red
			3'd6:    return 3'b001;  // Blue
			default: return 3'b000;  // Black
		endcase
	endfunction

	assign de_in = !raster.hblank && !raster.vblank;
	assign rgb   = bar_rgb(bar_idx);

	//////////////////////////////
	// Stage 1
	//////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			hsync_d1 <= 1'b0;
			vsync_d1 <= 1'b0;
			de_d1    <= 1'b0;
		end else begin
			hsync_d1 <= raster.hsync ^ timing.sync_neg;
			vsync_d1 <= raster.vsync ^ timing.sync_neg;
			de_d1    <= de_in;
		end
	end

	// Bar counter runs alongside de_d1, first active pixel starts at bar 0
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			pix_cnt <= '0;
			bar_idx <= '0;
		end else if (mode_change || !de_d1) begin
			pix_cnt <= '0;
			bar_idx <= '0;
		end else if (pix_cnt == timing.bar_width - 1'b1) begin
			pix_cnt <= '0;
			bar_idx <= bar_idx + 1'b1;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Stage 2
	//////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge rstbtn_n) begin
		if (!rstbtn_n) begin
			video <= '0;
		end else begin
			video.hsync <= hsync_d1;
			video.vsync <= vsync_d1;
			video.de    <= de_d1;
			video.red   <= de_d1 ? {`COLOR_W{rgb[2]}} : '0;  // Black outside active area
			video.green <= de_d1 ? {`COLOR_W{rgb[1]}} : '0;
			video.blue  <= de_d1 ? {`COLOR_W{rgb[0]}} : '0;
		end
	end

endmodule

// File: design/video_timing_top.sv
`include "video_macros.svh"

module video_timing_top
	import video_mode_pkg::*;
	import video_signal_pkg::*;
#(
	parameter int DEBOUNCE_LEN = `DEBOUNCE_LEN_DEF
) (
	input  logic       clk50m_bufg,
	input  logic       rstbtn_n,
	input  logic [3:0] sw,
	output video_out_t video
);

	mode_timing_t timing;
	logic         mode_change;   // Restarts the raster
	raster_t      raster;

	mode_select #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.rstbtn_n    (rstbtn_n),
		.sw          (sw),
		.timing      (timing),
		.mode_change (mode_change)
	);

	raster_counter i_raster_counter (
		.clk50m_bufg (clk50m_bufg),
		.rstbtn_n    (rstbtn_n),
		.timing      (timing),
		.mode_change (mode_change),
		.raster      (raster)
	);

	video_output_stage i_video_output_stage (
		.clk50m_bufg (clk50m_bufg),
		.rstbtn_n    (rstbtn_n),
		.timing      (timing),
		.mode_change (mode_change),
		.raster      (raster),
		.video       (video)
	);

endmodule

// File: verification/video_timing_checker.sv
module video_timing_checker
	import video_mode_pkg::*;
	import video_signal_pkg::*;
(
	input logic         clk50m_bufg,
	input logic         rstbtn_n,
	input mode_timing_t timing,
	input video_out_t   video
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;   // Failed assertions so far

	//////////////////////////////
	// Output rules
	//////////////////////////////
	a_blank_pixels: assert property (@(posedge clk50m_bufg) disable iff (!rstbtn_n)
		!video.de |-> (video.red == '0 && video.green == '0 && video.blue == '0))
	else begin
		fail_cnt++;
		$error("pixel data is not zero while de is low");
	end

	// Polarity taken from the same cycle as the raster that made this sync
	a_de_outside_hsync: assert property (@(posedge clk50m_bufg) disable iff (!rstbtn_n)
		video.de |-> !(video.hsync ^ $past(timing.sync_neg, 2)))
	else begin
		fail_cnt++;
		$error("de is high during the hsync pulse");
	end

	a_de_low_after_reset: assert property (@(posedge clk50m_bufg)
		$rose(rstbtn_n) |=> !video.de)
	else begin
		fail_cnt++;
		$error("de is high right after reset release");
	end

endmodule

// File: verification/video_timing_tb.sv
`include "video_macros.svh"

module video_timing_tb
	import video_signal_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DB_LEN      = 16;
	localparam int SETTLE      = DB_LEN + 3 + 12;   // Strobe latency plus pipeline
	localparam int LINE_LIMIT  = 4000;
	localparam int FRAME_LIMIT = 500000;

	// Porch values of one mode
	typedef struct packed {
		int h_act;
		int h_fp;
		int h_sw;
		int h_bp;
		int v_act;
		int v_fp;
		int v_sw;
		int v_bp;
		bit neg;
	} ref_mode_t;

	logic       clk50m_bufg;
	logic       rstbtn_n;
	logic [3:0] sw;
	video_out_t video;

	int n_checks;
	int n_errors;
	int test_errs;   // Errors before the current test

	// {r, g, b}: white, yellow, cyan, green, magenta, red, blue, black
	bit [2:0] bar_colors [`BAR_COUNT] = '{3'b111, 3'b110, 3'b011, 3'b010,
	                                      3'b101, 3'b100, 3'b001, 3'b000};

	video_timing_top #(.DEBOUNCE_LEN(DB_LEN)) i_dut (
		.clk50m_bufg (clk50m_bufg),
		.rstbtn_n    (rstbtn_n),
		.sw          (sw),
		.video       (video)
	);

	bind video_output_stage video_timing_checker i_checker (
		.clk50m_bufg (clk50m_bufg),
		.rstbtn_n    (rstbtn_n),
		.timing      (timing),
		.video       (video)
	);

	always #10 clk50m_bufg = ~clk50m_bufg;

	//////////////////////////////
	// Reference timing
	//////////////////////////////
	function automatic ref_mode_t ref_mode(input logic [3:0] code);
		if (code == 4'b0000) begin
			return '{640, 16, 96, 48, 480, 11, 2, 31, 1'b1};    // VGA
		end
		return '{1280, 110, 40, 220, 720, 5, 5, 20, 1'b0};     // 720p, also unused codes
	endfunction

	function automatic int h_total(input ref_mode_t m);
		return m.h_act + m.h_fp + m.h_sw + m.h_bp;
	endfunction

	function automatic int v_total(input ref_mode_t m);
		return m.v_act + m.v_fp + m.v_sw + m.v_bp;
	endfunction

	function automatic bit sync_active(input bit use_v, input bit neg);
		return (use_v ? video.vsync : video.hsync) ^ neg;
	endfunction

	//////////////////////////////
	// Checks and waits
	//////////////////////////////
	task automatic check_value(input string what, input int got, input int exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		n_errors++;
		$display("Timed out at %0t waiting for the %s", $time, what);
	endtask

	task automatic end_test(input string name);
		$display("%-24s %s", name, (n_errors == test_errs) ? "ok" : "failed");
		test_errs = n_errors;
	endtask

	// Returns on the first sample where sync turns active
	task automatic wait_sync_lead(input bit use_v, input bit neg, input int limit,
			output bit ok);
		bit prev;
		bit cur;
		ok = 1'b0;
		prev = sync_active(use_v, neg);
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge clk50m_bufg);
			cur = sync_active(use_v, neg);
			ok = cur && !prev;
			prev = cur;
		end
		if (!ok) begin
			report_timeout(use_v ? "vsync leading edge" : "hsync leading edge");
		end
	endtask

	// Measures from one sync leading edge to the next
	task automatic measure_sync(input bit use_v, input bit neg, input int limit,
			output int period, output int width, output int de_cnt,
			output int h_leads, output bit ok);
		bit prev_s;
		bit prev_h;
		bit cur_s;
		bit cur_h;
		period = 0;
		width = 1;
		de_cnt = 0;
		h_leads = 0;
		wait_sync_lead(use_v, neg, limit, ok);
		if (!ok) begin
			return;
		end
		ok = 1'b0;
		de_cnt = video.de;
		prev_s = sync_active(use_v, neg);
		prev_h = sync_active(1'b0, neg);
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge clk50m_bufg);
			period++;
			cur_s = sync_active(use_v, neg);
			cur_h = sync_active(1'b0, neg);
			if (cur_s && !prev_s) begin
				ok = 1'b1;
			end else begin
				width += cur_s;
				de_cnt += video.de;
				h_leads += (cur_h && !prev_h);
			end
			prev_s = cur_s;
			prev_h = cur_h;
		end
		if (!ok) begin
			report_timeout(use_v ? "next vsync edge" : "next hsync edge");
		end
	endtask

	task automatic wait_de_rise(input int limit, output bit ok);
		bit prev;
		ok = 1'b0;
		prev = video.de;
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge clk50m_bufg);
			ok = video.de && !prev;
			prev = video.de;
		end
		if (!ok) begin
			report_timeout("rising edge of de");
		end
	endtask

	// Short code change that starts on an hsync leading edge
	task automatic pulse_at_hsync(input bit neg, input logic [3:0] code,
			input logic [3:0] back);
		bit ok;
		wait_sync_lead(1'b0, neg, LINE_LIMIT, ok);
		if (ok) begin
			sw = code;
			repeat (DB_LEN / 2) @(negedge clk50m_bufg);
			sw = back;
		end
	endtask

	task automatic check_line(input logic [3:0] code, input string name);
		ref_mode_t m;
		int period;
		int width;
		int de_cnt;
		int h_leads;
		bit ok;
		m = ref_mode(code);
		measure_sync(1'b0, m.neg, LINE_LIMIT, period, width, de_cnt, h_leads, ok);
		if (ok) begin
			check_value({name, " line period"}, period, h_total(m));
			check_value({name, " hsync width"}, width, m.h_sw);
			check_value({name, " de per line"}, de_cnt, m.h_act);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic test_reset_720p();
		check_line(4'b0010, "720p");
		end_test("720p after reset");
	endtask

	task automatic test_switch_mode(input logic [3:0] code, input string name);
		sw = code;
		repeat (SETTLE) @(negedge clk50m_bufg);
		check_line(code, name);
		end_test({name, " switch"});
	endtask

	// The measured line spans the pulse, so a taken pulse would restart it
	task automatic test_short_pulse();
		ref_mode_t m;
		m = ref_mode(4'b0000);
		fork
			check_line(4'b0000, "VGA across pulse");
			pulse_at_hsync(m.neg, 4'b0011, 4'b0000);   // XGA, too short to be taken
		join
		end_test("short XGA pulse");
	endtask

	task automatic test_color_bars();
		ref_mode_t m;
		int bar_w;
		int exp_pix;
		bit [2:0] c;
		bit ok;
		m = ref_mode(4'b0000);
		bar_w = m.h_act / `BAR_COUNT;
		wait_de_rise(FRAME_LIMIT, ok);
		if (ok) begin
			for (int i = 0; i < m.h_act; i++) begin
				c = bar_colors[i / bar_w];
				exp_pix = {{`COLOR_W{c[2]}}, {`COLOR_W{c[1]}}, {`COLOR_W{c[0]}}};
				check_value($sformatf("pixel %0d", i),
				            {video.red, video.green, video.blue}, exp_pix);
				@(negedge clk50m_bufg);
			end
			check_value("de after active line", video.de, 0);
		end
		end_test("VGA colour bars");
	endtask

	task automatic test_vga_frame();
		ref_mode_t m;
		int period;
		int width;
		int de_cnt;
		int h_leads;
		bit ok;
		m = ref_mode(4'b0000);
		measure_sync(1'b1, m.neg, FRAME_LIMIT, period, width, de_cnt, h_leads, ok);
		if (ok) begin
			check_value("VGA lines per frame", h_leads, v_total(m));
			check_value("VGA vsync width", width, m.v_sw * h_total(m));
			check_value("VGA frame period", period, v_total(m) * h_total(m));
			check_value("VGA de per frame", de_cnt, m.v_act * m.h_act);
		end
		end_test("VGA frame");
	endtask

	initial begin
		clk50m_bufg = 1'b0;
		rstbtn_n    = 1'b0;
		sw          = 4'b0010;
		n_checks    = 0;
		n_errors    = 0;
		test_errs   = 0;
		repeat (10) @(negedge clk50m_bufg);
		rstbtn_n = 1'b1;
		test_reset_720p();
		test_switch_mode(4'b0000, "VGA");
		test_short_pulse();
		test_color_bars();
		test_vga_frame();
		test_switch_mode(4'b0101, "unused code");
		n_errors = n_errors + i_dut.i_video_output_stage.i_checker.fail_cnt;
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+include
design/video_mode_pkg.sv
design/video_signal_pkg.sv
design/mode_select.sv
design/raster_counter.sv
design/video_output_stage.sv
design/video_timing_top.sv
verification/video_timing_checker.sv
verification/video_timing_tb.sv

// File: Bender.yml
package:
  name: video_timing

export_include_dirs:
  - include

sources:
  - files:
      - design/video_mode_pkg.sv
      - design/video_signal_pkg.sv
      - design/mode_select.sv
      - design/raster_counter.sv
      - design/video_output_stage.sv
      - design/video_timing_top.sv
  - target: test
    files:
      - verification/video_timing_checker.sv
      - verification/video_timing_tb.sv
